// File: Bender.yml
package:
  name: cvxif_subsys

sources:
  - cvxif_pkg.sv
  - cvxif_fu.sv
  - copro_decoder.sv
  - copro_issue_queue.sv
  - copro_exec.sv
  - cvxif_subsys_top.sv
  - target: test
    files:
      - tb_cvxif_subsys.sv

// File: copro_decoder.sv
`default_nettype none

module copro_decoder (
    input  cvxif_pkg::x_req_t       x_req_i,
    input  logic                    queue_full_i,
    output logic                    issue_ready_o,
    output logic                    issue_accept_o,
    output logic                    push_o,
    output cvxif_pkg::copro_entry_t entry_o
);

    import cvxif_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic       supported;
    copro_op_e  op;

    // Standard R-type field positions
    assign opcode = x_req_i.issue_instr[6:0];
    assign funct3 = x_req_i.issue_instr[14:12];
    assign rd     = x_req_i.issue_instr[11:7];

    always_comb begin
        supported = 1'b0;
        op        = OP_ADD;
        if (opcode == OPC_CUSTOM0) begin
            case (funct3)
                F3_ADD: begin
                    supported = 1'b1;
                    op        = OP_ADD;
                end
                F3_XOR: begin
                    supported = 1'b1;
                    op        = OP_XOR;
                end
                F3_MUL: begin
                    supported = 1'b1;
                    op        = OP_MUL;
                end
                default: begin
                    supported = 1'b0;
                end
            endcase
        end
    end

    // Issue back-pressure comes straight from the queue
    assign issue_ready_o  = ~queue_full_i;
    assign issue_accept_o = x_req_i.issue_valid & supported;

    // Only accepted handshakes enter the queue
    assign push_o = x_req_i.issue_valid & issue_ready_o & supported;

    always_comb begin
        entry_o     = '0;
        entry_o.op  = op;
        entry_o.id  = x_req_i.issue_id;
        entry_o.rs1 = x_req_i.issue_rs[0];
        entry_o.rs2 = x_req_i.issue_rs[1];
        // Writes to x0 are dropped
        entry_o.we  = (rd != 5'd0);
    end

endmodule

`default_nettype wire

// File: copro_exec.sv
`default_nettype none

module copro_exec (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  cvxif_pkg::copro_entry_t  entry_i,
    input  logic                     empty_i,
    output logic                     pop_o,
    output cvxif_pkg::copro_result_t result_o,
    output logic                     result_valid_o
);

    import cvxif_pkg::*;

    localparam int unsigned CNT_W = $clog2(XLEN);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(XLEN - 1);

    logic                busy_q;
    logic [CNT_W-1:0]    step_q;
    logic                result_valid_q;
    copro_result_t       result_q;

    // Shift-add multiplier state
    logic [XLEN-1:0]     mcand_q;
    logic [XLEN-1:0]     mplier_q;
    logic [XLEN-1:0]     acc_q;
    logic [XLEN-1:0]     acc_step;

    // Take a new entry only when no MUL is running
    assign pop_o = ~busy_q & ~empty_i;

    assign acc_step = mplier_q[0] ? acc_q + mcand_q : acc_q;

    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q         <= 1'b0;
            step_q         <= '0;
            result_valid_q <= 1'b0;
        end else begin
            result_valid_q <= 1'b0;
            if (pop_o) begin
                if (entry_i.op == OP_MUL) begin
                    // First step is done in the pop cycle
                    busy_q <= 1'b1;
                    step_q <= CNT_W'(1);
                end else begin
                    result_valid_q <= 1'b1;
                end
            end else if (busy_q) begin
                if (step_q == LAST_STEP) begin
                    busy_q         <= 1'b0;
                    result_valid_q <= 1'b1;
                end else begin
                    step_q <= step_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            result_q.id <= entry_i.id;
            result_q.we <= entry_i.we;
            case (entry_i.op)
                OP_ADD: result_q.data <= entry_i.rs1 + entry_i.rs2;
                OP_XOR: result_q.data <= entry_i.rs1 ^ entry_i.rs2;
                default: begin
                    acc_q    <= entry_i.rs2[0] ? entry_i.rs1 : '0;
                    mcand_q  <= entry_i.rs1 << 1;
                    mplier_q <= entry_i.rs2 >> 1;
                end
            endcase
        end else if (busy_q) begin
            acc_q    <= acc_step;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            if (step_q == LAST_STEP) begin
                result_q.data <= acc_step;
            end
        end
    end

endmodule

`default_nettype wire

// File: copro_issue_queue.sv
`default_nettype none

module copro_issue_queue #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    push_i,
    input  cvxif_pkg::copro_entry_t entry_i,
    input  logic                    pop_i,
    output cvxif_pkg::copro_entry_t entry_o,
    output logic                    empty_o,
    output logic                    full_o
);

    import cvxif_pkg::*;

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    copro_entry_t            mem [DEPTH];
    logic        [PTR_W-1:0] wr_ptr_q;
    logic        [PTR_W-1:0] rd_ptr_q;
    logic        [CNT_W-1:0] count_q;
    logic                    do_push;
    logic                    do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign entry_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap explicitly so DEPTH need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

// File: cvxif_fu.sv
`default_nettype none

module cvxif_fu (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  cvxif_pkg::fu_data_t                 fu_data_i,
    // Issue side
    input  logic                                x_valid_i,
    output logic                                x_ready_o,
    input  logic [31:0]                         x_off_instr_i,
    // Writeback side
    output logic [cvxif_pkg::TRANS_ID_BITS-1:0] x_trans_id_o,
    output cvxif_pkg::exception_t               x_exception_o,
    output logic [cvxif_pkg::XLEN-1:0]          x_result_o,
    output logic                                x_valid_o,
    output logic                                x_we_o,
    // Coprocessor side
    output cvxif_pkg::x_req_t                   core_v_xif_req_o,
    input  cvxif_pkg::x_resp_t                  core_v_xif_resp_i
);

    import cvxif_pkg::*;

    // Single-entry slot for a rejected instruction
    logic                     illegal_q;
    logic                     illegal_d;
    logic [TRANS_ID_BITS-1:0] illegal_id_q;
    logic [31:0]              illegal_instr_q;

    logic                     reject;
    logic                     pending;
    logic [TRANS_ID_BITS-1:0] pending_id;
    logic [31:0]              pending_instr;

    // Issue request, blocked while an earlier rejection is still unreported
    always_comb begin
        core_v_xif_req_o              = '0;
        core_v_xif_req_o.result_ready = 1'b1;
        if (x_valid_i && !illegal_q) begin
            core_v_xif_req_o.issue_valid = 1'b1;
            core_v_xif_req_o.issue_instr = x_off_instr_i;
            core_v_xif_req_o.issue_id    = fu_data_i.trans_id;
            core_v_xif_req_o.issue_rs[0] = fu_data_i.operand_a;
            core_v_xif_req_o.issue_rs[1] = fu_data_i.operand_b;
            core_v_xif_req_o.rs_valid    = 2'b11;
        end
    end

    assign x_ready_o = core_v_xif_resp_i.issue_ready & ~illegal_q;

    // Handshake completed but the coprocessor declined the instruction
    assign reject = core_v_xif_req_o.issue_valid & core_v_xif_resp_i.issue_ready
                    & ~core_v_xif_resp_i.issue_accept;

    // A fresh rejection can only occur while the slot is empty
    assign pending       = illegal_q | reject;
    assign pending_id    = reject ? core_v_xif_req_o.issue_id : illegal_id_q;
    assign pending_instr = reject ? core_v_xif_req_o.issue_instr : illegal_instr_q;

    // Writeback merge, coprocessor results win over the illegal report
    always_comb begin
        x_valid_o     = core_v_xif_resp_i.result_valid;
        x_trans_id_o  = '0;
        x_result_o    = '0;
        x_we_o        = 1'b0;
        x_exception_o = '0;
        illegal_d     = pending;
        if (core_v_xif_resp_i.result_valid) begin
            x_trans_id_o        = core_v_xif_resp_i.result_id;
            x_result_o          = core_v_xif_resp_i.result_data;
            x_we_o              = core_v_xif_resp_i.result_we;
            x_exception_o.valid = core_v_xif_resp_i.result_exc;
            x_exception_o.cause = core_v_xif_resp_i.result_exccode;
        end else if (pending) begin
            x_valid_o           = 1'b1;
            x_trans_id_o        = pending_id;
            x_exception_o.valid = 1'b1;
            x_exception_o.cause = EXC_ILLEGAL_INSTR;
            x_exception_o.tval  = pending_instr;
            // Reported now, slot is free next cycle
            illegal_d           = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            illegal_q <= 1'b0;
        end else begin
            illegal_q <= illegal_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reject) begin
            illegal_id_q    <= core_v_xif_req_o.issue_id;
            illegal_instr_q <= core_v_xif_req_o.issue_instr;
        end
    end

endmodule

`default_nettype wire

// File: cvxif_pkg.sv
`default_nettype none

package cvxif_pkg;

    // Data and identifier widths
    localparam int unsigned XLEN           = 32;
    localparam int unsigned TRANS_ID_BITS  = 3;
    localparam int unsigned EXC_CAUSE_BITS = 4;

    // Exception cause for instructions the coprocessor refuses
    localparam logic [EXC_CAUSE_BITS-1:0] EXC_ILLEGAL_INSTR = 4'd2;

    // Custom-0 major opcode and the accepted funct3 values
    localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;
    localparam logic [2:0] F3_ADD      = 3'd0;
    localparam logic [2:0] F3_XOR      = 3'd1;
    localparam logic [2:0] F3_MUL      = 3'd2;

    // Operands handed over by the issue stage
    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
    } fu_data_t;

    typedef struct packed {
        logic [EXC_CAUSE_BITS-1:0] cause;
        logic                      valid;
        logic [XLEN-1:0]           tval;
    } exception_t;

    // Core to coprocessor, two source registers only
    typedef struct packed {
        logic                      issue_valid;
        logic [31:0]               issue_instr;
        logic [TRANS_ID_BITS-1:0]  issue_id;
        logic [1:0][XLEN-1:0]      issue_rs;
        logic [1:0]                rs_valid;
        logic                      result_ready;
    } x_req_t;

    // Coprocessor to core
    typedef struct packed {
        logic                      issue_ready;
        logic                      issue_accept;
        logic                      result_valid;
        logic [TRANS_ID_BITS-1:0]  result_id;
        logic [XLEN-1:0]           result_data;
        logic                      result_we;
        logic                      result_exc;
        logic [EXC_CAUSE_BITS-1:0] result_exccode;
    } x_resp_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_XOR,
        OP_MUL
    } copro_op_e;

    // One decoded operation waiting for the execution unit
    typedef struct packed {
        copro_op_e                op;
        logic [TRANS_ID_BITS-1:0] id;
        logic [XLEN-1:0]          rs1;
        logic [XLEN-1:0]          rs2;
        logic                     we;
    } copro_entry_t;

    typedef struct packed {
        logic [TRANS_ID_BITS-1:0] id;
        logic [XLEN-1:0]          data;
        logic                     we;
    } copro_result_t;

endpackage

`default_nettype wire

// File: cvxif_subsys_top.sv
`default_nettype none

module cvxif_subsys_top #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  cvxif_pkg::fu_data_t                 fu_data_i,
    input  logic                                x_valid_i,
    output logic                                x_ready_o,
    input  logic [31:0]                         x_off_instr_i,
    output logic [cvxif_pkg::TRANS_ID_BITS-1:0] x_trans_id_o,
    output cvxif_pkg::exception_t               x_exception_o,
    output logic [cvxif_pkg::XLEN-1:0]          x_result_o,
    output logic                                x_valid_o,
    output logic                                x_we_o
);

    import cvxif_pkg::*;

    x_req_t        xif_req;
    x_resp_t       xif_resp;
    logic          issue_ready;
    logic          issue_accept;
    logic          push;
    logic          pop;
    logic          queue_empty;
    logic          queue_full;
    copro_entry_t  dec_entry;
    copro_entry_t  head_entry;
    copro_result_t exec_result;
    logic          exec_valid;

    // Response assembled from decoder and execution unit
    assign xif_resp.issue_ready    = issue_ready;
    assign xif_resp.issue_accept   = issue_accept;
    assign xif_resp.result_valid   = exec_valid;
    assign xif_resp.result_id      = exec_result.id;
    assign xif_resp.result_data    = exec_result.data;
    assign xif_resp.result_we      = exec_result.we;
    assign xif_resp.result_exc     = 1'b0;
    assign xif_resp.result_exccode = '0;

    cvxif_fu u_fu (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .fu_data_i         (fu_data_i),
        .x_valid_i         (x_valid_i),
        .x_ready_o         (x_ready_o),
        .x_off_instr_i     (x_off_instr_i),
        .x_trans_id_o      (x_trans_id_o),
        .x_exception_o     (x_exception_o),
        .x_result_o        (x_result_o),
        .x_valid_o         (x_valid_o),
        .x_we_o            (x_we_o),
        .core_v_xif_req_o  (xif_req),
        .core_v_xif_resp_i (xif_resp)
    );

    copro_decoder u_decoder (
        .x_req_i        (xif_req),
        .queue_full_i   (queue_full),
        .issue_ready_o  (issue_ready),
        .issue_accept_o (issue_accept),
        .push_o         (push),
        .entry_o        (dec_entry)
    );

    copro_issue_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (push),
        .entry_i (dec_entry),
        .pop_i   (pop),
        .entry_o (head_entry),
        .empty_o (queue_empty),
        .full_o  (queue_full)
    );

    copro_exec u_exec (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .entry_i        (head_entry),
        .empty_i        (queue_empty),
        .pop_o          (pop),
        .result_o       (exec_result),
        .result_valid_o (exec_valid)
    );

endmodule

`default_nettype wire

// File: list.f
cvxif_pkg.sv
cvxif_fu.sv
copro_decoder.sv
copro_issue_queue.sv
copro_exec.sv
cvxif_subsys_top.sv
tb_cvxif_subsys.sv

// File: tb_cvxif_subsys.sv
`default_nettype none

module tb_cvxif_subsys;

    import cvxif_pkg::*;

    localparam int NUM_IDS       = 2 ** TRANS_ID_BITS;
    localparam int WAIT_TIMEOUT  = 500;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int RANDOM_COUNT  = 400;

    // Instruction kinds produced by the stimulus
    localparam int K_ADD     = 0;
    localparam int K_XOR     = 1;
    localparam int K_MUL     = 2;
    localparam int K_BAD_F3  = 3;
    localparam int K_BAD_OPC = 4;

    logic                     clk_i;
    logic                     rst_ni;
    fu_data_t                 fu_data;
    logic                     x_valid_i;
    logic                     x_ready_o;
    logic [31:0]              x_off_instr_i;
    logic [TRANS_ID_BITS-1:0] x_trans_id_o;
    exception_t               x_exception_o;
    logic [XLEN-1:0]          x_result_o;
    logic                     x_valid_o;
    logic                     x_we_o;

    // Scoreboard indexed by transaction id
    logic                     inflight    [NUM_IDS];
    logic                     exp_illegal [NUM_IDS];
    logic [31:0]              exp_instr   [NUM_IDS];
    logic [XLEN-1:0]          exp_data    [NUM_IDS];
    logic                     exp_we      [NUM_IDS];
    logic [TRANS_ID_BITS-1:0] order_q [$];

    logic [31:0] lcg_state = 32'd47541;
    int          errors    = 0;
    int          issued    = 0;
    int          completed = 0;
    int          stalls    = 0;

    cvxif_subsys_top #(
        .QUEUE_DEPTH (4)
    ) u_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fu_data_i     (fu_data),
        .x_valid_i     (x_valid_i),
        .x_ready_o     (x_ready_o),
        .x_off_instr_i (x_off_instr_i),
        .x_trans_id_o  (x_trans_id_o),
        .x_exception_o (x_exception_o),
        .x_result_o    (x_result_o),
        .x_valid_o     (x_valid_o),
        .x_we_o        (x_we_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Reference model of the three coprocessor operations
    function automatic logic [XLEN-1:0] model_result(int kind, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] product;
        product = (2*XLEN)'(a) * (2*XLEN)'(b);
        case (kind)
            K_ADD:   return a + b;
            K_XOR:   return a ^ b;
            default: return product[XLEN-1:0];
        endcase
    endfunction

    task automatic finish_run();
        $display("summary: %0d issued, %0d completed, %0d errors", issued, completed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        $display("TIMEOUT: %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_mark);
        $display("test %-14s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
    endtask

    // Writeback monitor, samples just before the rising edge
    task automatic check_writeback();
        logic [TRANS_ID_BITS-1:0] id;
        id = x_trans_id_o;
        if (x_exception_o.valid) begin
            assert (inflight[id] && exp_illegal[id]) else begin
                $display("illegal report for id %0d that has no rejected instruction", id);
                errors++;
            end
            check_value("x_exception_o.cause", 32'(x_exception_o.cause), 32'(EXC_ILLEGAL_INSTR));
            check_value("x_exception_o.tval", x_exception_o.tval, exp_instr[id]);
            check_value("x_we_o", 32'(x_we_o), 32'd0);
            check_value("x_result_o", x_result_o, 32'd0);
        end else begin
            assert (order_q.size() > 0) else begin
                $display("result for id %0d arrived with no legal instruction outstanding", id);
                errors++;
            end
            if (order_q.size() > 0) begin
                id = order_q.pop_front();
                check_value("x_trans_id_o", 32'(x_trans_id_o), 32'(id));
                check_value("x_result_o", x_result_o, exp_data[id]);
                check_value("x_we_o", 32'(x_we_o), 32'(exp_we[id]));
            end
        end
        inflight[id] = 1'b0;
        completed++;
    endtask

    initial begin
        forever begin
            @(negedge clk_i);
            #4;
            if (rst_ni && x_valid_o) begin
                check_writeback();
            end
        end
    end

    function automatic bit any_inflight();
        for (int i = 0; i < NUM_IDS; i++) begin
            if (inflight[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Picks a random id that is not in flight, called on a falling edge
    task automatic take_free_id(output logic [TRANS_ID_BITS-1:0] id);
        logic [TRANS_ID_BITS-1:0] free_ids [$];
        int                       n;
        n = 0;
        do begin
            free_ids.delete();
            for (int i = 0; i < NUM_IDS; i++) begin
                if (!inflight[i]) begin
                    free_ids.push_back(TRANS_ID_BITS'(i));
                end
            end
            if (free_ids.size() == 0) begin
                @(negedge clk_i);
                n++;
            end
        end while (free_ids.size() == 0 && n < WAIT_TIMEOUT);
        if (free_ids.size() == 0) begin
            fail_timeout("no free transaction id became available");
        end else begin
            id = free_ids[(rand_next() >> 16) % free_ids.size()];
        end
    endtask

    // Builds one instruction of the given kind and issues it, starting on a falling edge
    task automatic issue_random(input int kind, input bit rd_nonzero);
        logic [TRANS_ID_BITS-1:0] id;
        logic [31:0]              r;
        logic [XLEN-1:0]          a;
        logic [XLEN-1:0]          b;
        logic [4:0]               rd;
        logic [2:0]               f3;
        logic [6:0]               opc;
        int                       n;
        a   = rand_next();
        b   = rand_next();
        r   = rand_next();
        rd  = (!rd_nonzero && r[9:8] == 2'd0) ? 5'd0 : 5'(1 + (r >> 11) % 31);
        opc = OPC_CUSTOM0;
        case (kind)
            K_ADD:    f3 = F3_ADD;
            K_XOR:    f3 = F3_XOR;
            K_MUL:    f3 = F3_MUL;
            K_BAD_F3: f3 = 3'(3 + (r >> 20) % 5);
            default: begin
                f3  = 3'((r >> 20) % 3);
                opc = (r[6:0] == OPC_CUSTOM0) ? 7'b0101011 : r[6:0];
            end
        endcase
        take_free_id(id);
        x_valid_i        = 1'b1;
        x_off_instr_i    = {r[31:25], a[4:0], b[4:0], f3, rd, opc};
        fu_data.trans_id = id;
        fu_data.operand_a = a;
        fu_data.operand_b = b;
        #2;
        n = 0;
        if (!x_ready_o) begin
            stalls++;
        end
        while (!x_ready_o && n < WAIT_TIMEOUT) begin
            @(negedge clk_i);
            #2;
            n++;
        end
        if (!x_ready_o) begin
            fail_timeout("x_ready_o stayed low with an instruction waiting");
        end else begin
            // Handshake happens at the coming rising edge
            inflight[id]    = 1'b1;
            exp_illegal[id] = (kind > K_MUL);
            exp_instr[id]   = x_off_instr_i;
            exp_data[id]    = model_result(kind, a, b);
            exp_we[id]      = (rd != 5'd0);
            if (kind <= K_MUL) begin
                order_q.push_back(id);
            end
            issued++;
            @(negedge clk_i);
            x_valid_i = 1'b0;
        end
    endtask

    task automatic drain(input string name);
        int n;
        n = 0;
        while (any_inflight() && n < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (any_inflight()) begin
            fail_timeout({"outstanding instructions never completed in ", name});
        end else begin
            check_value("completed count", completed, issued);
            check_value("order queue size", order_q.size(), 32'd0);
        end
    endtask

    initial begin
        int          err_mark;
        int          stall_mark;
        int          kind;
        int          gap;
        logic [31:0] r;
        for (int i = 0; i < NUM_IDS; i++) begin
            inflight[i] = 1'b0;
        end
        rst_ni        = 1'b0;
        x_valid_i     = 1'b0;
        x_off_instr_i = '0;
        fu_data       = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        err_mark = errors;
        #4;
        check_value("x_valid_o", 32'(x_valid_o), 32'd0);
        check_value("x_ready_o", 32'(x_ready_o), 32'd1);
        report_test("reset", err_mark);
        @(negedge clk_i);

        // One MUL followed by enough ADDs to fill the queue
        err_mark   = errors;
        stall_mark = stalls;
        issue_random(K_MUL, 1'b1);
        repeat (6) issue_random(K_ADD, 1'b1);
        drain("backpressure");
        assert (stalls > stall_mark) else begin
            $display("x_ready_o never dropped while the queue filled behind a MUL");
            errors++;
        end
        report_test("backpressure", err_mark);

        err_mark = errors;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            r    = rand_next();
            kind = (r >> 8) % 8;
            if (kind > K_BAD_OPC) begin
                kind = kind - 5;
            end
            gap = (r[20:18] < 3'd4) ? 0 : int'(r[17:16]);
            repeat (gap) @(negedge clk_i);
            issue_random(kind, 1'b0);
        end
        drain("random run");
        report_test("random mix", err_mark);

        finish_run();
    end

endmodule

`default_nettype wire
